/* source/tx_switch_pkg.sv */
package tx_switch_pkg;

	// client index, up to 8 clients
	localparam int CLIENT_W = 3;

	// frame length in bytes, 0 stands for 256
	localparam int LEN_W = 8;

	// one queue entry
	typedef struct packed {
		logic [CLIENT_W-1:0] idx;
		logic [LEN_W-1:0]    len;
	} tx_req_t;

	typedef struct packed {
		logic    valid;
		tx_req_t req;
	} tx_grant_t;

	// per-client request life cycle
	typedef enum logic [1:0] {
		PORT_IDLE    = 2'd0,
		PORT_PENDING = 2'd1,
		PORT_QUEUED  = 2'd2,
		PORT_SENDING = 2'd3
	} port_state_t;

	typedef enum logic {
		SEND_IDLE = 1'b0,
		SEND_BUSY = 1'b1
	} send_state_t;

endpackage

/* source/req_queue.sv */
`timescale 1ns/1ps

module req_queue #(
	parameter int AW = 3,
	parameter int DW = 11
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          wr_en,
	input  logic [DW-1:0] din,
	input  logic          rd_en,
	output logic [DW-1:0] dout,
	output logic          dout_valid,
	output logic          empty,
	output logic          full,
	output logic [AW:0]   count
);

	localparam int DEPTH = 1 << AW;

	logic [DW-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign empty = (count == '0);
	assign full  = (count == (AW+1)'(DEPTH));
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
		// output word registered on each read
		if (do_rd) begin
			dout <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= do_rd;
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_wr != do_rd) begin
				count <= do_wr ? count + 1'b1 : count - 1'b1;
			end
		end
	end

endmodule

/* source/tx_client_port.sv */
`timescale 1ns/1ps

module tx_client_port #(
	parameter int IDX = 0
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                req,
	input  logic [tx_switch_pkg::LEN_W-1:0]     len,
	output logic                                busy,
	output logic                                ack,
	output logic                                pend,
	output tx_switch_pkg::tx_req_t              pend_req,
	input  logic                                acpt,
	input  tx_switch_pkg::tx_grant_t            grant,
	input  logic                                done,
	input  logic [tx_switch_pkg::CLIENT_W-1:0]  done_idx
);

	localparam int CW = tx_switch_pkg::CLIENT_W;
	localparam logic [CW-1:0] MY_IDX = CW'(IDX);

	tx_switch_pkg::port_state_t      state;
	tx_switch_pkg::port_state_t      state_nxt;
	logic [tx_switch_pkg::LEN_W-1:0] len_q;
	logic                            granted;
	logic                            finished;

	assign granted  = grant.valid && (grant.req.idx == MY_IDX);
	assign finished = done && (done_idx == MY_IDX);

	assign busy     = (state != tx_switch_pkg::PORT_IDLE);
	assign pend     = (state == tx_switch_pkg::PORT_PENDING);
	assign ack      = (state == tx_switch_pkg::PORT_QUEUED) && granted;
	assign pend_req = '{idx: MY_IDX, len: len_q};

	always_comb begin
		state_nxt = state;
		case (state)
			tx_switch_pkg::PORT_IDLE:    if (req) state_nxt = tx_switch_pkg::PORT_PENDING;
			tx_switch_pkg::PORT_PENDING: if (acpt) state_nxt = tx_switch_pkg::PORT_QUEUED;
			tx_switch_pkg::PORT_QUEUED:  if (granted) state_nxt = tx_switch_pkg::PORT_SENDING;
			tx_switch_pkg::PORT_SENDING: if (finished) state_nxt = tx_switch_pkg::PORT_IDLE;
			default:                     state_nxt = tx_switch_pkg::PORT_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= tx_switch_pkg::PORT_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// length taken only from an idle port
	always_ff @(posedge clk) begin
		if (state == tx_switch_pkg::PORT_IDLE && req) begin
			len_q <= len;
		end
	end

endmodule

/* source/tx_arbiter.sv */
`timescale 1ns/1ps

module tx_arbiter #(
	parameter int N_CLIENTS = 4,
	parameter int QUEUE_AW  = 3
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic [N_CLIENTS-1:0]                    pend,
	input  tx_switch_pkg::tx_req_t [N_CLIENTS-1:0]  pend_req,
	output logic [N_CLIENTS-1:0]                    acpt,
	input  logic                                    sender_busy,
	output tx_switch_pkg::tx_grant_t                grant,
	output logic [QUEUE_AW:0]                       queue_depth
);

	localparam int DW = $bits(tx_switch_pkg::tx_req_t);

	tx_switch_pkg::tx_req_t push_req;
	tx_switch_pkg::tx_req_t q_dout;
	tx_switch_pkg::tx_req_t grant_req;
	logic                   grant_valid;
	logic                   push;
	logic                   pop;
	logic                   q_valid;
	logic                   q_empty;
	logic                   q_full;

	// fixed priority, lowest pending index wins
	always_comb begin
		acpt     = '0;
		push_req = '0;
		if (!q_full) begin
			for (int i = N_CLIENTS - 1; i >= 0; i--) begin
				if (pend[i]) begin
					acpt     = '0;
					acpt[i]  = 1'b1;
					push_req = pend_req[i];
				end
			end
		end
	end

	assign push = |acpt;

	// one pop at a time: wait out the read, the grant and the frame
	assign pop = !q_empty && !sender_busy && !q_valid && !grant_valid;

	req_queue #(
		.AW (QUEUE_AW),
		.DW (DW)
	) i_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (push),
		.din        (push_req),
		.rd_en      (pop),
		.dout       (q_dout),
		.dout_valid (q_valid),
		.empty      (q_empty),
		.full       (q_full),
		.count      (queue_depth)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_valid <= 1'b0;
		end else begin
			grant_valid <= q_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (q_valid) begin
			grant_req <= q_dout;
		end
	end

	assign grant = '{valid: grant_valid, req: grant_req};

endmodule

/* source/tx_frame_sender.sv */
`timescale 1ns/1ps

module tx_frame_sender #(
	parameter int N_CLIENTS = 4
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  tx_switch_pkg::tx_grant_t            grant,
	input  logic [N_CLIENTS*8-1:0]              client_data,
	output logic [N_CLIENTS-1:0]                client_rd,
	output logic                                tx_valid,
	output logic [7:0]                          tx_data,
	output logic                                tx_last,
	input  logic                                tx_ready,
	output logic                                busy,
	output logic                                done,
	output logic [tx_switch_pkg::CLIENT_W-1:0]  done_idx
);

	tx_switch_pkg::send_state_t         state;
	logic [tx_switch_pkg::CLIENT_W-1:0] idx_q;
	logic [tx_switch_pkg::LEN_W-1:0]    remain;
	logic                               hs;

	assign busy     = (state == tx_switch_pkg::SEND_BUSY);
	assign tx_valid = busy;
	assign tx_data  = client_data[idx_q*8 +: 8];

	// remain counts bytes left after the current one
	assign tx_last  = busy && (remain == '0);
	assign hs       = tx_valid && tx_ready;

	// client moves to its next byte after each handshake
	assign client_rd = hs ? (N_CLIENTS'(1) << idx_q) : '0;

	assign done     = hs && tx_last;
	assign done_idx = idx_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= tx_switch_pkg::SEND_IDLE;
		end else begin
			case (state)
				tx_switch_pkg::SEND_IDLE: begin
					if (grant.valid) begin
						state <= tx_switch_pkg::SEND_BUSY;
					end
				end
				tx_switch_pkg::SEND_BUSY: begin
					if (done) begin
						state <= tx_switch_pkg::SEND_IDLE;
					end
				end
				default: begin
					state <= tx_switch_pkg::SEND_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == tx_switch_pkg::SEND_IDLE && grant.valid) begin
			idx_q  <= grant.req.idx;
			// zero length wraps to 255, i.e. a 256 byte frame
			remain <= grant.req.len - 1'b1;
		end else if (hs) begin
			remain <= remain - 1'b1;
		end
	end

endmodule

/* source/tx_switch_top.sv */
`timescale 1ns/1ps

module tx_switch_top #(
	parameter int N_CLIENTS = 4,
	parameter int QUEUE_AW  = 3
) (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic [N_CLIENTS-1:0]                       client_req,
	input  logic [N_CLIENTS*tx_switch_pkg::LEN_W-1:0]  client_len,
	output logic [N_CLIENTS-1:0]                       client_busy,
	output logic [N_CLIENTS-1:0]                       client_ack,
	input  logic [N_CLIENTS*8-1:0]                     client_data,
	output logic [N_CLIENTS-1:0]                       client_rd,
	output logic                                       tx_valid,
	output logic [7:0]                                 tx_data,
	output logic                                       tx_last,
	input  logic                                       tx_ready,
	output logic [QUEUE_AW:0]                          queue_depth
);

	localparam int LW = tx_switch_pkg::LEN_W;

	logic [N_CLIENTS-1:0]                   pend;
	tx_switch_pkg::tx_req_t [N_CLIENTS-1:0] pend_req;
	logic [N_CLIENTS-1:0]                   acpt;
	tx_switch_pkg::tx_grant_t               grant;
	logic                                   sender_busy;
	logic                                   done;
	logic [tx_switch_pkg::CLIENT_W-1:0]     done_idx;

	for (genvar i = 0; i < N_CLIENTS; i++) begin : g_port
		tx_client_port #(
			.IDX (i)
		) i_port (
			.clk      (clk),
			.rst_n    (rst_n),
			.req      (client_req[i]),
			.len      (client_len[i*LW +: LW]),
			.busy     (client_busy[i]),
			.ack      (client_ack[i]),
			.pend     (pend[i]),
			.pend_req (pend_req[i]),
			.acpt     (acpt[i]),
			.grant    (grant),
			.done     (done),
			.done_idx (done_idx)
		);
	end

	tx_arbiter #(
		.N_CLIENTS (N_CLIENTS),
		.QUEUE_AW  (QUEUE_AW)
	) i_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.pend        (pend),
		.pend_req    (pend_req),
		.acpt        (acpt),
		.sender_busy (sender_busy),
		.grant       (grant),
		.queue_depth (queue_depth)
	);

	tx_frame_sender #(
		.N_CLIENTS (N_CLIENTS)
	) i_sender (
		.clk         (clk),
		.rst_n       (rst_n),
		.grant       (grant),
		.client_data (client_data),
		.client_rd   (client_rd),
		.tx_valid    (tx_valid),
		.tx_data     (tx_data),
		.tx_last     (tx_last),
		.tx_ready    (tx_ready),
		.busy        (sender_busy),
		.done        (done),
		.done_idx    (done_idx)
	);

endmodule

/* dv/tx_switch_tb.sv */
`timescale 1ns/1ps

module tx_switch_tb;

	localparam int N  = 4;
	localparam int AW = 3;
	localparam int LW = tx_switch_pkg::LEN_W;

	logic            clk = 1'b0;
	logic            rst_n;
	logic [N-1:0]    client_req;
	logic [N*LW-1:0] client_len;
	logic [N-1:0]    client_busy;
	logic [N-1:0]    client_ack;
	logic [N*8-1:0]  client_data;
	logic [N-1:0]    client_rd;
	logic            tx_valid;
	logic [7:0]      tx_data;
	logic            tx_last;
	logic            tx_ready;
	logic [AW:0]     queue_depth;

	int          errors = 0;
	int          n_req = 0;
	int          n_ack = 0;
	int          n_frames = 0;
	logic [15:0] lfsr = 16'd30;
	logic [7:0]  rd_cnt [N] = '{default: '0};
	int          exp_pos [N] = '{default: 0};
	int          req_len [N] = '{default: 0};
	bit          acked [N];
	int          ack_q [$];
	int          ack_log [$];
	bit          in_frame = 1'b0;
	int          cur_idx;
	int          byte_cnt;
	bit          held = 1'b0;
	logic [7:0]  hold_data;
	logic        hold_last;

	tx_switch_top #(
		.N_CLIENTS (N),
		.QUEUE_AW  (AW)
	) i_dut (.*);

	always #4 clk = ~clk;

	// modelled clients step through their bytes on client_rd
	always @(posedge clk) begin
		for (int k = 0; k < N; k++) begin
			if (client_rd[k]) begin
				rd_cnt[k] <= rd_cnt[k] + 1'b1;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < N; k++) begin
			client_data[k*8 +: 8] = 8'(k * 64) + rd_cnt[k];
		end
	end

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one step per bit taken
	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_val(input string name, input int exp, input int act);
		assert (exp == act) else begin
			errors++;
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic raise_req(input int k, input int len);
		client_req[k] = 1'b1;
		client_len[k*LW +: LW] = LW'(len);
		req_len[k] = len;
		n_req++;
	endtask

	task automatic drive_cycle(input bit allow_req);
		int v;
		client_req = '0;
		for (int k = 0; k < N && allow_req; k++) begin
			take_bits(2, v);
			if (v == 0 && !client_busy[k]) begin
				take_bits(4, v);
				raise_req(k, v % 12 + 1);
			end
		end
		take_bits(2, v);
		tx_ready = (v != 0);
		@(posedge clk);
		#1;
	endtask

	function automatic bit drained();
		return client_busy == '0 && !tx_valid;
	endfunction

	task automatic wait_drained(input string phase);
		int t;
		t = 0;
		while (!drained() && t < 5000) begin
			drive_cycle(1'b0);
			t++;
		end
		if (!drained()) begin
			errors++;
			$display("timeout: requests of the %s phase never finished", phase);
		end else begin
			check_val("queue_depth_idle", 0, int'(queue_depth));
		end
	endtask

	a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(client_ack))
		else begin
			errors++;
			$display("FAILED ack_onehot expected one-hot actual %b", $sampled(client_ack));
		end

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(|client_ack) |=> (client_ack == '0))
		else begin
			errors++;
			$display("FAILED ack_pulse expected 0 actual %b", $sampled(client_ack));
		end

	a_depth_max: assert property (@(posedge clk) disable iff (!rst_n) int'(queue_depth) <= N)
		else begin
			errors++;
			$display("FAILED depth_max expected <= %0d actual %0d", N, $sampled(queue_depth));
		end

	// scoreboard sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (held) begin
				check_val("tx_hold_data", int'(hold_data), int'(tx_data));
				check_val("tx_hold_last", int'(hold_last), int'(tx_last));
			end
			held = tx_valid && !tx_ready;
			hold_data = tx_data;
			hold_last = tx_last;
			for (int k = 0; k < N; k++) begin
				if (client_ack[k]) begin
					check_val("ack_outstanding", 1, int'(req_len[k] != 0 && !acked[k]));
					acked[k] = 1'b1;
					ack_q.push_back(k);
					ack_log.push_back(k);
					n_ack++;
				end
			end
			if (tx_valid && !in_frame) begin
				cur_idx = 0;
				if (ack_q.size() == 0) begin
					errors++;
					$display("frame appeared on the link with no client acknowledged");
				end else begin
					cur_idx = ack_q.pop_front();
				end
				in_frame = 1'b1;
				byte_cnt = 0;
			end
			if (tx_valid && tx_ready && in_frame) begin
				check_val("frame_data", (cur_idx * 64 + exp_pos[cur_idx]) % 256, int'(tx_data));
				check_val("frame_last", int'(byte_cnt + 1 == req_len[cur_idx]), int'(tx_last));
				exp_pos[cur_idx]++;
				byte_cnt++;
				if (tx_last) begin
					in_frame = 1'b0;
					req_len[cur_idx] = 0;
					acked[cur_idx] = 1'b0;
					n_frames++;
				end
			end
		end
	end

	initial begin
		int v;
		rst_n = 1'b0;
		client_req = '0;
		client_len = '0;
		tx_ready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		check_val("reset_state", 0, int'({tx_valid, tx_last, client_ack, client_rd,
			client_busy, queue_depth}));

		for (int c = 0; c < 2000; c++) begin
			drive_cycle(1'b1);
		end
		wait_drained("random");

		// all clients at once with the link stalled
		ack_log.delete();
		for (int k = 0; k < N; k++) begin
			take_bits(4, v);
			raise_req(k, v % 12 + 1);
		end
		tx_ready = 1'b0;
		@(posedge clk);
		#1;
		client_req = '0;
		repeat (24) begin
			@(posedge clk);
			#1;
		end
		wait_drained("burst");
		check_val("burst_acks", N, ack_log.size());
		for (int i = 0; i < ack_log.size(); i++) begin
			check_val("burst_order", i, ack_log[i]);
		end

		check_val("ack_count", n_req, n_ack);
		check_val("frame_count", n_req, n_frames);
		$display("%0d requests, %0d acks, %0d frames, %0d errors", n_req, n_ack, n_frames, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
source/tx_switch_pkg.sv
source/req_queue.sv
source/tx_client_port.sv
source/tx_arbiter.sv
source/tx_frame_sender.sv
source/tx_switch_top.sv
dv/tx_switch_tb.sv

/* Makefile */
TOP = tx_switch_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f verilog.f \
		--top-module tx_switch_top

clean:
	rm -rf obj_dir
